// File: verilog/pcie_pkg.sv
/*
 * Host-side transaction types and the register map of the bridge.
 * Decoded PIO writes, read requests and completions use these structs.
 */
`default_nettype none

package pcie_pkg;

   // decoded PIO write, address is a 64-bit word index
   typedef struct packed {
      logic [5:0]  address;
      logic [63:0] data;
   } pio_write_t;

   // register index lives in addr[4:1]
   typedef struct packed {
      logic [23:0] rid_tag;
      logic [7:0]  addr;
   } read_req_t;

   // dw2 carries requester/tag and lower address back to TX
   typedef struct packed {
      logic [31:0] dw2;
      logic [31:0] data;
   } completion_t;

   // PIO write addresses
   localparam logic [5:0] ADDR_RESET_SET = 6'd3;
   localparam logic [5:0] ADDR_RESET_CLR = 6'd4;
   localparam logic [5:0] ADDR_FPC_DATA  = 6'd8;

   // read register indices, anything else reads zero
   localparam logic [3:0] REG_INT_STATUS = 4'd0;
   localparam logic [3:0] REG_ENABLE     = 4'd1;
   localparam logic [3:0] REG_RESET_A    = 4'd3;
   localparam logic [3:0] REG_RESET_B    = 4'd4;
   localparam logic [3:0] REG_FPC_STATUS = 4'd8;
   localparam logic [3:0] REG_TPC_STATUS = 4'd12;

   // only channels 0 and 4 are built
   localparam logic [7:0] ENABLE_MASK = 8'h11;

endpackage

`default_nettype wire

// File: verilog/fifo_pkg.sv
/*
 * Channel-side payloads, the channel status word and the bit positions
 * of each channel in the interrupt status and the reset register.
 */
`default_nettype none

package fifo_pkg;

   typedef logic [63:0] fpc_word_t;

   // end_mark closes a burst early
   typedef struct packed {
      logic [63:0] data;
      logic        end_mark;
   } tpc_word_t;

   typedef struct packed {
      logic [63:0] data;
      logic        last;
   } wr_beat_t;

   typedef struct packed {
      logic [15:0] count;
      logic [13:0] zero;
      logic        full;
      logic        overflow;
   } chan_status_t;

   // done in bit 0, drop in bit 1
   typedef struct packed {
      logic drop;
      logic done;
   } chan_irq_t;

   localparam int FPC_IRQ_BASE  = 0;
   localparam int TPC_IRQ_BASE  = 8;
   localparam int FPC_RESET_BIT = 0;
   localparam int TPC_RESET_BIT = 4;

endpackage

`default_nettype wire

// File: verilog/sync_fifo.sv
/*
 * Single-clock first-word-fall-through FIFO, payload type set by parameter.
 * head is valid whenever empty is low; clear empties it like a reset.
 */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo
  #(
   parameter int DEPTH = 16,
   parameter type payload_t = logic
   )
  (
   input wire logic        clock,
   input wire logic        pci_reset,
   input wire logic        clear,
   input wire logic        push,
   input wire payload_t    push_data,
   input wire logic        pop,
   output payload_t        head,
   output logic            empty,
   output logic            full,
   output logic [15:0]     count
   );

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   payload_t mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic push_ok;
   logic pop_ok;

   // overflow and underflow are the caller's business
   assign push_ok = push & ~full;
   assign pop_ok  = pop & ~empty;

   assign empty = (count == 16'd0);
   assign full  = (count == 16'(DEPTH));
   assign head  = mem[rd_ptr];

   always_ff @(posedge clock)
   begin
      if (push_ok)
         mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clock)
   begin
      if (pci_reset | clear)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= 16'd0;
      end
      else
      begin
         // explicit wrap so any depth works
         if (push_ok)
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop_ok)
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count <= count + 16'(push_ok) - 16'(pop_ok);
      end
   end

endmodule

`default_nettype wire

// File: verilog/fpc_channel.sv
/*
 * From-PC channel: host PIO words are buffered here until the user pops them.
 * Reports occupancy and a sticky overflow, and pulses drain and drop events.
 */
`timescale 1ns/1ps
`default_nettype none

module fpc_channel
  #(
   parameter int FPC_DEPTH = 16
   )
  (
   input wire logic               clock,
   input wire logic               pci_reset,
   input wire logic               chan_reset,
   input wire logic               fpc_push,
   input wire fifo_pkg::fpc_word_t fpc_push_data,
   input wire logic               fpc_read,
   output fifo_pkg::fpc_word_t    fpc_data,
   output logic                   fpc_valid,
   output fifo_pkg::chan_status_t status,
   output fifo_pkg::chan_irq_t    irq
   );

   logic        empty;
   logic        full;
   logic [15:0] count;
   logic        push_ok;
   logic        pop_ok;
   logic        overflow;

   sync_fifo
     #(
      .DEPTH     (FPC_DEPTH),
      .payload_t (fifo_pkg::fpc_word_t)
      )
   u_fifo
     (
      .clock     (clock),
      .pci_reset (pci_reset),
      .clear     (chan_reset),
      .push      (fpc_push & ~chan_reset),
      .push_data (fpc_push_data),
      .pop       (fpc_read & ~chan_reset),
      .head      (fpc_data),
      .empty     (empty),
      .full      (full),
      .count     (count)
      );

   assign push_ok = fpc_push & ~chan_reset & ~full;
   assign pop_ok  = fpc_read & ~chan_reset & ~empty;

   // hidden from the user while the channel is held in reset
   assign fpc_valid = ~empty & ~chan_reset;

   // last word popped and nothing arriving on the same edge
   assign irq.done = pop_ok & (count == 16'd1) & ~push_ok;
   assign irq.drop = fpc_push & ~chan_reset & full;

   always_ff @(posedge clock)
   begin
      if (pci_reset | chan_reset)
         overflow <= 1'b0;
      else if (irq.drop)
         overflow <= 1'b1;
   end

   assign status.count    = count;
   assign status.zero     = '0;
   assign status.full     = full;
   assign status.overflow = overflow;

endmodule

`default_nettype wire

// File: verilog/tpc_channel.sv
/*
 * To-PC channel: user words are buffered and drained as bursts of write beats.
 * A burst starts once BURST words or an end mark are held and closes on the
 * marked word or the BURST-th beat.
 */
`timescale 1ns/1ps
`default_nettype none

module tpc_channel
  #(
   parameter int TPC_DEPTH = 32,
   parameter int BURST     = 8
   )
  (
   input wire logic                clock,
   input wire logic                pci_reset,
   input wire logic                chan_reset,
   input wire logic                tpc_write,
   input wire fifo_pkg::tpc_word_t tpc_word,
   input wire logic                wr_ready,
   output logic                    tpc_ready,
   output logic                    wr_valid,
   output fifo_pkg::wr_beat_t      wr_beat,
   output fifo_pkg::chan_status_t  status,
   output fifo_pkg::chan_irq_t     irq
   );

   localparam int BW = $clog2(BURST + 1);

   fifo_pkg::tpc_word_t head;
   logic          empty;
   logic          full;
   logic [15:0]   count;
   logic [15:0]   mark_count;
   logic          push_ok;
   logic          beat_ok;
   logic          in_burst;
   logic [BW-1:0] beat_cnt;
   logic          overflow;

   sync_fifo
     #(
      .DEPTH     (TPC_DEPTH),
      .payload_t (fifo_pkg::tpc_word_t)
      )
   u_fifo
     (
      .clock     (clock),
      .pci_reset (pci_reset),
      .clear     (chan_reset),
      .push      (push_ok),
      .push_data (tpc_word),
      .pop       (beat_ok),
      .head      (head),
      .empty     (empty),
      .full      (full),
      .count     (count)
      );

   assign tpc_ready = ~full & ~chan_reset;
   assign push_ok   = tpc_write & tpc_ready;

   // a burst never runs dry, its words are all held before it starts
   assign wr_valid     = in_burst & ~empty & ~chan_reset;
   assign wr_beat.data = head.data;
   assign wr_beat.last = head.end_mark | (beat_cnt == BW'(BURST - 1));
   assign beat_ok      = wr_valid & wr_ready;

   assign irq.done = beat_ok & wr_beat.last;
   assign irq.drop = tpc_write & ~chan_reset & full;

   always_ff @(posedge clock)
   begin
      if (pci_reset | chan_reset)
      begin
         in_burst   <= 1'b0;
         beat_cnt   <= '0;
         mark_count <= 16'd0;
         overflow   <= 1'b0;
      end
      else
      begin
         // marked words currently held in the buffer
         mark_count <= mark_count + 16'(push_ok & tpc_word.end_mark)
                       - 16'(beat_ok & head.end_mark);
         if (irq.drop)
            overflow <= 1'b1;
         if (!in_burst)
         begin
            if ((count >= 16'(BURST)) || (mark_count != 16'd0))
               in_burst <= 1'b1;
            beat_cnt <= '0;
         end
         else if (beat_ok)
         begin
            if (wr_beat.last)
            begin
               in_burst <= 1'b0;
               beat_cnt <= '0;
            end
            else
               beat_cnt <= beat_cnt + 1'b1;
         end
      end
   end

   assign status.count    = count;
   assign status.zero     = '0;
   assign status.full     = full;
   assign status.overflow = overflow;

endmodule

`default_nettype wire

// File: verilog/hififo_regs.sv
/*
 * Register block: decodes PIO writes, answers register reads through a
 * two-stage pipeline into a held completion, collects channel events into
 * the clear-on-read interrupt status and raises the interrupt request.
 */
`timescale 1ns/1ps
`default_nettype none

module hififo_regs
  (
   input wire logic                   clock,
   input wire logic                   pci_reset,
   input wire logic                   pio_valid,
   input wire pcie_pkg::pio_write_t   pio,
   input wire logic                   rd_valid,
   input wire pcie_pkg::read_req_t    rd_req,
   input wire logic                   cpl_ready,
   input wire logic                   interrupt_rdy,
   input wire fifo_pkg::chan_status_t fpc_status,
   input wire fifo_pkg::chan_status_t tpc_status,
   input wire fifo_pkg::chan_irq_t    fpc_irq,
   input wire fifo_pkg::chan_irq_t    tpc_irq,
   output logic                       rd_ready,
   output logic                       cpl_valid,
   output pcie_pkg::completion_t      cpl,
   output logic                       interrupt,
   output logic                       fpc_push,
   output fifo_pkg::fpc_word_t        fpc_push_data,
   output logic                       fpc_reset,
   output logic                       tpc_reset
   );

   logic [7:0]  reset_reg;
   logic [15:0] int_status;
   logic [15:0] irq_events;
   logic [1:0]  read_stage;
   logic        read_in_progress;
   logic        cpl_accept;
   logic        read_clear;
   logic [3:0]  reg_index;
   logic [31:0] reg_data;

   assign reg_index  = rd_req.addr[4:1];
   assign cpl_accept = cpl_valid & cpl_ready;

   // interrupt status clears when its read reaches the second stage
   assign read_clear = read_stage[1] & (reg_index == pcie_pkg::REG_INT_STATUS);

   always_comb
   begin
      irq_events = 16'd0;
      irq_events[fifo_pkg::FPC_IRQ_BASE +: 2] = fpc_irq;
      irq_events[fifo_pkg::TPC_IRQ_BASE +: 2] = tpc_irq;
   end

   always_comb
   begin
      case (reg_index)
         pcie_pkg::REG_INT_STATUS:
            reg_data = {16'd0, int_status};
         pcie_pkg::REG_ENABLE:
            reg_data = {24'd0, pcie_pkg::ENABLE_MASK};
         pcie_pkg::REG_RESET_A, pcie_pkg::REG_RESET_B:
            reg_data = {24'd0, reset_reg};
         pcie_pkg::REG_FPC_STATUS:
            reg_data = fpc_status;
         pcie_pkg::REG_TPC_STATUS:
            reg_data = tpc_status;
         default:
            reg_data = 32'd0;
      endcase
   end

   assign fpc_reset = reset_reg[fifo_pkg::FPC_RESET_BIT];
   assign tpc_reset = reset_reg[fifo_pkg::TPC_RESET_BIT];

   always_ff @(posedge clock)
   begin
      if (pci_reset)
      begin
         reset_reg        <= 8'hFF;
         int_status       <= 16'd0;
         interrupt        <= 1'b0;
         read_stage       <= 2'b00;
         read_in_progress <= 1'b0;
         rd_ready         <= 1'b0;
         cpl_valid        <= 1'b0;
         fpc_push         <= 1'b0;
      end
      else
      begin
         // set and clear writes take the low byte as a mask
         if (pio_valid && (pio.address == pcie_pkg::ADDR_RESET_SET))
            reset_reg <= reset_reg | pio.data[7:0];
         else if (pio_valid && (pio.address == pcie_pkg::ADDR_RESET_CLR))
            reset_reg <= reset_reg & ~pio.data[7:0];
         fpc_push <= pio_valid && (pio.address == pcie_pkg::ADDR_FPC_DATA);

         // a clear in the same cycle as an event loses that event
         if (read_clear)
            int_status <= 16'd0;
         else
            int_status <= int_status | irq_events;
         interrupt <= (irq_events != 16'd0) | (interrupt & ~interrupt_rdy);

         // one read in flight until the requester has seen rd_ready
         if (cpl_accept)
            read_in_progress <= 1'b0;
         else if (rd_valid & ~rd_ready)
            read_in_progress <= 1'b1;
         read_stage[0] <= rd_valid & ~read_in_progress & ~rd_ready;
         read_stage[1] <= read_stage[0];
         rd_ready      <= cpl_accept;
         if (cpl_accept)
            cpl_valid <= 1'b0;
         else if (read_stage[1])
            cpl_valid <= 1'b1;
      end
   end

   always_ff @(posedge clock)
   begin
      fpc_push_data <= pio.data;
      if (read_stage[1])
      begin
         cpl.dw2  <= {rd_req.rid_tag, 1'b0, rd_req.addr[4:0], 2'b00};
         cpl.data <= reg_data;
      end
   end

endmodule

`default_nettype wire

// File: verilog/hififo_top.sv
/*
 * PCIe to FIFO bridge control subsystem, one from-PC and one to-PC channel.
 * Host side takes decoded PIO writes and read requests; user side is a
 * pop interface and a push interface with a burst write output.
 */
`timescale 1ns/1ps
`default_nettype none

module hififo_top
  #(
   parameter int FPC_DEPTH = 16,
   parameter int TPC_DEPTH = 32,
   parameter int BURST     = 8
   )
  (
   input wire logic                 clock,
   input wire logic                 pci_reset,
   // host side
   input wire logic                 pio_valid,
   input wire pcie_pkg::pio_write_t pio,
   input wire logic                 rd_valid,
   input wire pcie_pkg::read_req_t  rd_req,
   output logic                     rd_ready,
   output logic                     cpl_valid,
   output pcie_pkg::completion_t    cpl,
   input wire logic                 cpl_ready,
   output logic                     interrupt,
   input wire logic                 interrupt_rdy,
   // from-PC user side
   output logic                     fpc_valid,
   output fifo_pkg::fpc_word_t      fpc_data,
   input wire logic                 fpc_read,
   // to-PC user side
   input wire logic                 tpc_write,
   input wire fifo_pkg::tpc_word_t  tpc_word,
   output logic                     tpc_ready,
   output logic                     wr_valid,
   output fifo_pkg::wr_beat_t       wr_beat,
   input wire logic                 wr_ready
   );

   logic                   fpc_push;
   fifo_pkg::fpc_word_t    fpc_push_data;
   logic                   fpc_reset;
   logic                   tpc_reset;
   fifo_pkg::chan_status_t fpc_status;
   fifo_pkg::chan_status_t tpc_status;
   fifo_pkg::chan_irq_t    fpc_irq;
   fifo_pkg::chan_irq_t    tpc_irq;

   hififo_regs u_regs
     (
      .clock         (clock),
      .pci_reset     (pci_reset),
      .pio_valid     (pio_valid),
      .pio           (pio),
      .rd_valid      (rd_valid),
      .rd_req        (rd_req),
      .cpl_ready     (cpl_ready),
      .interrupt_rdy (interrupt_rdy),
      .fpc_status    (fpc_status),
      .tpc_status    (tpc_status),
      .fpc_irq       (fpc_irq),
      .tpc_irq       (tpc_irq),
      .rd_ready      (rd_ready),
      .cpl_valid     (cpl_valid),
      .cpl           (cpl),
      .interrupt     (interrupt),
      .fpc_push      (fpc_push),
      .fpc_push_data (fpc_push_data),
      .fpc_reset     (fpc_reset),
      .tpc_reset     (tpc_reset)
      );

   fpc_channel #(.FPC_DEPTH(FPC_DEPTH)) u_fpc
     (
      .clock         (clock),
      .pci_reset     (pci_reset),
      .chan_reset    (fpc_reset),
      .fpc_push      (fpc_push),
      .fpc_push_data (fpc_push_data),
      .fpc_read      (fpc_read),
      .fpc_data      (fpc_data),
      .fpc_valid     (fpc_valid),
      .status        (fpc_status),
      .irq           (fpc_irq)
      );

   tpc_channel #(.TPC_DEPTH(TPC_DEPTH), .BURST(BURST)) u_tpc
     (
      .clock      (clock),
      .pci_reset  (pci_reset),
      .chan_reset (tpc_reset),
      .tpc_write  (tpc_write),
      .tpc_word   (tpc_word),
      .wr_ready   (wr_ready),
      .tpc_ready  (tpc_ready),
      .wr_valid   (wr_valid),
      .wr_beat    (wr_beat),
      .status     (tpc_status),
      .irq        (tpc_irq)
      );

endmodule

`default_nettype wire

// File: sim/hififo_chk.sv
/*
 * Protocol assertions for the register block, bound into every hififo_regs.
 * Covers completion hold, rd_ready pulse width, interrupt hold and PIO push.
 */
`timescale 1ns/1ps
`default_nettype none

module hififo_chk
  (
   input wire logic                  clock,
   input wire logic                  pci_reset,
   input wire logic                  cpl_valid,
   input wire logic                  cpl_ready,
   input wire pcie_pkg::completion_t cpl,
   input wire logic                  rd_ready,
   input wire logic                  interrupt,
   input wire logic                  interrupt_rdy,
   input wire logic                  fpc_push,
   input wire logic                  pio_valid
   );

   // completion is held until taken
   assert property (@(posedge clock) disable iff (pci_reset)
      cpl_valid && !cpl_ready |=> cpl_valid && $stable(cpl))
      else $error("completion dropped or changed before cpl_ready");

   assert property (@(posedge clock) disable iff (pci_reset)
      rd_ready |=> !rd_ready)
      else $error("rd_ready longer than one cycle");

   assert property (@(posedge clock) disable iff (pci_reset)
      interrupt && !interrupt_rdy |=> interrupt)
      else $error("interrupt fell before interrupt_rdy");

   // push is the registered decode of a PIO strobe
   assert property (@(posedge clock) disable iff (pci_reset)
      fpc_push |-> $past(pio_valid))
      else $error("fpc_push without a PIO write");

endmodule

bind hififo_regs hififo_chk u_chk
  (
   .clock         (clock),
   .pci_reset     (pci_reset),
   .cpl_valid     (cpl_valid),
   .cpl_ready     (cpl_ready),
   .cpl           (cpl),
   .rd_ready      (rd_ready),
   .interrupt     (interrupt),
   .interrupt_rdy (interrupt_rdy),
   .fpc_push      (fpc_push),
   .pio_valid     (pio_valid)
   );

`default_nettype wire

// File: sim/tb_hififo.sv
/*
 * Testbench for hififo_top: random register reads, reset control, both
 * channel data paths, interrupts and completion back-pressure, all checked
 * against a model kept here. Run from list.f with tb_hififo as top.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_hififo;

   localparam int FPC_DEPTH = 16;
   localparam int BURST     = 8;
   // rough cycle budget per test, summed for the watchdog
   localparam int TOTAL_CYCLES = 16 + 300 + 1500 + 2500 + 1200 + 800;

   logic clock;
   logic pci_reset;
   logic pio_valid;
   pcie_pkg::pio_write_t pio;
   logic rd_valid;
   pcie_pkg::read_req_t rd_req;
   logic rd_ready;
   logic cpl_valid;
   pcie_pkg::completion_t cpl;
   logic cpl_ready;
   logic interrupt;
   logic interrupt_rdy;
   logic fpc_valid;
   fifo_pkg::fpc_word_t fpc_data;
   logic fpc_read;
   logic tpc_write;
   fifo_pkg::tpc_word_t tpc_word;
   logic tpc_ready;
   logic wr_valid;
   fifo_pkg::wr_beat_t wr_beat;
   logic wr_ready;

   // reference model state
   logic [63:0] fpc_q[$];
   fifo_pkg::wr_beat_t tpc_exp[$];
   int burst_k;
   logic fpc_ovf;
   logic [7:0] reset_model;
   logic [15:0] int_model;
   logic [31:0] rng;
   int errors;
   int checks;

   hififo_top u_dut
     (
      .clock(clock), .pci_reset(pci_reset),
      .pio_valid(pio_valid), .pio(pio),
      .rd_valid(rd_valid), .rd_req(rd_req), .rd_ready(rd_ready),
      .cpl_valid(cpl_valid), .cpl(cpl), .cpl_ready(cpl_ready),
      .interrupt(interrupt), .interrupt_rdy(interrupt_rdy),
      .fpc_valid(fpc_valid), .fpc_data(fpc_data), .fpc_read(fpc_read),
      .tpc_write(tpc_write), .tpc_word(tpc_word), .tpc_ready(tpc_ready),
      .wr_valid(wr_valid), .wr_beat(wr_beat), .wr_ready(wr_ready)
      );

   initial
   begin
      clock = 1'b0;
      forever #4 clock = ~clock;
   end

   initial
   begin
      #(TOTAL_CYCLES * 8 + 2000);
      $display("watchdog expired: the tests did not finish in time");
      $display("TEST RESULT: FAIL");
      $finish;
   end

   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp)
      begin
         $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   // all stimulus changes 1 ns after a rising edge
   task automatic tick();
      @(posedge clock);
      #1;
   endtask

   task automatic reg_read(input logic [3:0] idx, input int max_hold, output logic [31:0] data);
      logic [31:0] r;
      pcie_pkg::read_req_t req;
      pcie_pkg::completion_t held;
      int n;
      int hold;
      r = next_rand();
      req.addr = {r[7:5], idx, r[0]};
      r = next_rand();
      req.rid_tag = r[23:0];
      rd_valid = 1'b1;
      rd_req = req;
      n = 0;
      while (!cpl_valid && n < 20)
      begin
         tick();
         n++;
      end
      if (!cpl_valid)
      begin
         $display("no completion arrived for a read of register %0d", idx);
         errors++;
         rd_valid = 1'b0;
         data = '0;
         return;
      end
      compare("completion latency", n, 3);
      compare("cpl.dw2", cpl.dw2, {req.rid_tag, 1'b0, req.addr[4:0], 2'b00});
      held = cpl;
      hold = next_rand() % (max_hold + 1);
      repeat (hold)
      begin
         tick();
         compare("cpl_valid held", cpl_valid, 1);
         compare("cpl held", cpl, held);
      end
      cpl_ready = 1'b1;
      tick();
      cpl_ready = 1'b0;
      compare("cpl_valid after accept", cpl_valid, 0);
      compare("rd_ready", rd_ready, 1);
      data = held.data;
      tick();
      rd_valid = 1'b0;
      compare("rd_ready pulse", rd_ready, 0);
      // a second completion for the same request would show here
      repeat (3)
      begin
         tick();
         compare("cpl_valid idle", cpl_valid, 0);
      end
   endtask

   task automatic read_expect(input string what, input logic [3:0] idx, input logic [31:0] exp);
      logic [31:0] d;
      reg_read(idx, 0, d);
      compare(what, d, exp);
   endtask

   task automatic pio_write(input logic [5:0] a, input logic [63:0] d);
      pio_valid = 1'b1;
      pio.address = a;
      pio.data = d;
      tick();
      pio_valid = 1'b0;
      tick();
      tick();
   endtask

   task automatic fpc_push_word();
      logic [63:0] d;
      d = {next_rand(), next_rand()};
      pio_write(pcie_pkg::ADDR_FPC_DATA, d);
      if (fpc_q.size() == FPC_DEPTH)
      begin
         fpc_ovf = 1'b1;
         int_model[fifo_pkg::FPC_IRQ_BASE + 1] = 1'b1;
      end
      else
         fpc_q.push_back(d);
   endtask

   task automatic fpc_pop_word();
      if (fpc_q.size() > 0)
      begin
         compare("fpc_valid", fpc_valid, 1);
         compare("fpc_data", fpc_data, fpc_q[0]);
      end
      else
         compare("fpc_valid empty", fpc_valid, 0);
      fpc_read = 1'b1;
      tick();
      fpc_read = 1'b0;
      if (fpc_q.size() > 0)
      begin
         void'(fpc_q.pop_front());
         if (fpc_q.size() == 0)
            int_model[fifo_pkg::FPC_IRQ_BASE] = 1'b1;
      end
   endtask

   function automatic logic [31:0] status_word(input int cnt, input int depth, input logic ovf);
      return {16'(cnt), 14'd0, cnt == depth, ovf};
   endfunction

   // one cycle on the to-PC side, acc tells whether a write was taken
   task automatic tpc_step(input logic wr, input logic mark, input logic force_wr,
                           input logic ready, output logic acc);
      fifo_pkg::wr_beat_t b;
      acc = 1'b0;
      wr_ready = ready;
      if (wr && (tpc_ready || force_wr))
      begin
         tpc_write = 1'b1;
         tpc_word.data = {next_rand(), next_rand()};
         tpc_word.end_mark = mark;
         if (tpc_ready)
         begin
            acc = 1'b1;
            b.data = tpc_word.data;
            b.last = mark || (burst_k == BURST - 1);
            burst_k = b.last ? 0 : burst_k + 1;
            tpc_exp.push_back(b);
         end
         else
            int_model[fifo_pkg::TPC_IRQ_BASE + 1] = 1'b1;
      end
      tick();
      tpc_write = 1'b0;
   endtask

   // beats are taken on the next rising edge
   always @(negedge clock)
   begin
      if (!pci_reset && wr_valid && wr_ready)
      begin
         if (tpc_exp.size() == 0)
         begin
            $display("a write beat was sent that no user word accounts for");
            errors++;
         end
         else
         begin
            compare("wr_beat.data", wr_beat.data, tpc_exp[0].data);
            compare("wr_beat.last", wr_beat.last, tpc_exp[0].last);
            if (tpc_exp[0].last)
               int_model[fifo_pkg::TPC_IRQ_BASE] = 1'b1;
            void'(tpc_exp.pop_front());
         end
      end
   end

   task automatic tpc_drain(input int limit);
      logic acc;
      int n;
      n = 0;
      while (tpc_exp.size() > 0 && n < limit)
      begin
         tpc_step(0, 0, 0, 1, acc);
         n++;
      end
      if (tpc_exp.size() > 0)
      begin
         $display("the to-PC channel stopped sending beats before it was empty");
         errors++;
      end
   endtask

   task automatic report(input string name, input int err_before);
      $display("test %s: %0d errors", name, errors - err_before);
   endtask

   initial
   begin
      logic [31:0] r;
      logic [31:0] d;
      logic acc;
      logic mark;
      int e0;
      int sent;
      int n;
      rng = 32'ha0d1_23f8;
      errors = 0;
      checks = 0;
      burst_k = 0;
      fpc_ovf = 1'b0;
      reset_model = 8'hFF;
      int_model = 16'd0;
      pci_reset = 1'b1;
      pio_valid = 1'b0;
      pio = '0;
      rd_valid = 1'b0;
      rd_req = '0;
      cpl_ready = 1'b0;
      interrupt_rdy = 1'b0;
      fpc_read = 1'b0;
      tpc_write = 1'b0;
      tpc_word = '0;
      wr_ready = 1'b0;
      repeat (16) @(posedge clock);
      #1;
      pci_reset = 1'b0;

      e0 = errors;
      compare("cpl_valid after reset", cpl_valid, 0);
      compare("rd_ready after reset", rd_ready, 0);
      compare("interrupt after reset", interrupt, 0);
      compare("wr_valid after reset", wr_valid, 0);
      compare("fpc_valid after reset", fpc_valid, 0);
      compare("tpc_ready after reset", tpc_ready, 0);
      read_expect("REG_ENABLE", pcie_pkg::REG_ENABLE, 32'h11);
      read_expect("REG_RESET_A", pcie_pkg::REG_RESET_A, 32'hFF);
      read_expect("REG_RESET_B", pcie_pkg::REG_RESET_B, 32'hFF);
      read_expect("REG_INT_STATUS", pcie_pkg::REG_INT_STATUS, 32'h0);
      read_expect("unmapped register", 4'd2, 32'h0);
      report("reset state", e0);

      e0 = errors;
      repeat (12)
      begin
         r = next_rand();
         if (r[8])
         begin
            pio_write(pcie_pkg::ADDR_RESET_SET, {next_rand(), 24'(next_rand()), r[7:0]});
            reset_model = reset_model | r[7:0];
         end
         else
         begin
            pio_write(pcie_pkg::ADDR_RESET_CLR, {next_rand(), 24'(next_rand()), r[7:0]});
            reset_model = reset_model & ~r[7:0];
         end
         compare("tpc_ready vs reset bit", tpc_ready, !reset_model[fifo_pkg::TPC_RESET_BIT]);
         if (reset_model[fifo_pkg::FPC_RESET_BIT])
            compare("fpc_valid in reset", fpc_valid, 0);
         read_expect("reset register", r[9] ? pcie_pkg::REG_RESET_B : pcie_pkg::REG_RESET_A,
                     {24'd0, reset_model});
      end
      pio_write(pcie_pkg::ADDR_RESET_CLR, 64'hFF);
      reset_model = 8'h00;
      pio_write(pcie_pkg::ADDR_FPC_DATA, 64'h1234);
      compare("fpc_valid out of reset", fpc_valid, 1);
      pio_write(pcie_pkg::ADDR_RESET_SET, 64'h01);
      compare("fpc_valid held in reset", fpc_valid, 0);
      pio_write(pcie_pkg::ADDR_RESET_CLR, 64'h01);
      compare("fpc_valid after channel reset", fpc_valid, 0);
      compare("tpc_ready released", tpc_ready, 1);
      report("reset set and clear", e0);

      e0 = errors;
      for (n = 0; n < 120; n++)
      begin
         r = next_rand();
         if (r[2:0] < 3'd5)
            fpc_push_word();
         else
            fpc_pop_word();
         if (n % 16 == 15)
            read_expect("REG_FPC_STATUS", pcie_pkg::REG_FPC_STATUS,
                        status_word(fpc_q.size(), FPC_DEPTH, fpc_ovf));
      end
      compare("fpc overflow seen", fpc_ovf, 1);
      while (fpc_q.size() > 0)
         fpc_pop_word();
      read_expect("REG_FPC_STATUS drained", pcie_pkg::REG_FPC_STATUS,
                  status_word(0, FPC_DEPTH, fpc_ovf));
      read_expect("REG_INT_STATUS after from-PC", pcie_pkg::REG_INT_STATUS, {16'd0, int_model});
      int_model = 16'd0;
      report("from-PC data path", e0);

      e0 = errors;
      sent = 0;
      n = 0;
      while ((sent < 64 || tpc_exp.size() > 0) && n < 2400)
      begin
         r = next_rand();
         mark = (sent == 63) || (r[4:2] == 3'd0);
         tpc_step((sent < 64) && (r[0] | r[1]), mark, 0, r[5] | r[6], acc);
         if (acc)
            sent++;
         n++;
      end
      if (n >= 2400)
      begin
         $display("the to-PC bursts did not finish within the cycle limit");
         errors++;
      end
      report("to-PC bursts", e0);

      e0 = errors;
      compare("interrupt pending", interrupt, 1);
      interrupt_rdy = 1'b1;
      tick();
      interrupt_rdy = 1'b0;
      compare("interrupt after ack", interrupt, 0);
      read_expect("REG_INT_STATUS accumulated", pcie_pkg::REG_INT_STATUS, {16'd0, int_model});
      int_model = 16'd0;
      read_expect("REG_INT_STATUS cleared", pcie_pkg::REG_INT_STATUS, 32'h0);
      // fill the to-PC buffer with the beats stalled, one write too many
      repeat (33)
         tpc_step(1, 0, 1, 0, acc);
      compare("interrupt on drop", interrupt, 1);
      repeat (1 + next_rand() % 6)
      begin
         tick();
         compare("interrupt held", interrupt, 1);
      end
      repeat (FPC_DEPTH + 1)
         fpc_push_word();
      while (fpc_q.size() > 0)
         fpc_pop_word();
      tpc_drain(400);
      read_expect("REG_TPC_STATUS", pcie_pkg::REG_TPC_STATUS, 32'h1);
      read_expect("REG_INT_STATUS events", pcie_pkg::REG_INT_STATUS, {16'd0, int_model});
      int_model = 16'd0;
      read_expect("REG_INT_STATUS second read", pcie_pkg::REG_INT_STATUS, 32'h0);
      interrupt_rdy = 1'b1;
      tick();
      interrupt_rdy = 1'b0;
      compare("interrupt released", interrupt, 0);
      report("interrupts", e0);

      e0 = errors;
      repeat (24)
      begin
         r = next_rand();
         case (r[1:0])
            2'd0:
            begin
               reg_read(pcie_pkg::REG_ENABLE, 7, d);
               compare("enable", d, 32'h11);
            end
            2'd1:
            begin
               reg_read(pcie_pkg::REG_RESET_B, 7, d);
               compare("reset", d, 32'h0);
            end
            2'd2:
            begin
               reg_read(pcie_pkg::REG_FPC_STATUS, 7, d);
               compare("fpc status", d, status_word(0, FPC_DEPTH, fpc_ovf));
            end
            default:
            begin
               reg_read(4'd7, 7, d);
               compare("unmapped", d, 32'h0);
            end
         endcase
      end
      report("completion back-pressure", e0);

      $display("6 tests run, %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
verilog/pcie_pkg.sv
verilog/fifo_pkg.sv
verilog/sync_fifo.sv
verilog/fpc_channel.sv
verilog/tpc_channel.sv
verilog/hififo_regs.sv
verilog/hififo_top.sv
sim/hififo_chk.sv
sim/tb_hififo.sv

// File: Bender.yml
package:
  name: hififo

sources:
  - verilog/pcie_pkg.sv
  - verilog/fifo_pkg.sv
  - verilog/sync_fifo.sv
  - verilog/fpc_channel.sv
  - verilog/tpc_channel.sv
  - verilog/hififo_regs.sv
  - verilog/hififo_top.sv
  - target: simulation
    files:
      - sim/hififo_chk.sv
      - sim/tb_hififo.sv
